// File: load_store_queue.sv
/* Load/store queue
   Circular buffer with head, execution and tail pointers and rewind on replay */
`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module load_store_queue
    import mem_unit_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       flush_i,
    input  mem_instr_t instr_i,
    output logic       full_o,
    queue_if.lsq       q
);

    localparam int PTR_W = $clog2(`MEM_LSQ_DEPTH);

    // One extra bit on each pointer tells full from empty
    logic [PTR_W:0] head_q;
    logic [PTR_W:0] exec_q;
    logic [PTR_W:0] tail_q;
    logic           wr_en;

    mem_instr_t entries_q [`MEM_LSQ_DEPTH];

    assign full_o = (tail_q[PTR_W] != head_q[PTR_W]) &&
                    (tail_q[PTR_W-1:0] == head_q[PTR_W-1:0]);

    assign wr_en = instr_i.valid & ~full_o;

    assign q.empty      = (exec_q == tail_q);
    assign q.head_instr = entries_q[exec_q[PTR_W-1:0]];

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            entries_q[tail_q[PTR_W-1:0]] <= instr_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            exec_q <= '0;
            tail_q <= '0;
        end else if (flush_i) begin
            head_q <= '0;
            exec_q <= '0;
            tail_q <= '0;
        end else begin
            if (wr_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (q.retire) begin
                head_q <= head_q + 1'b1;
            end
            // Nack restarts issue from the oldest entry
            if (q.replay) begin
                exec_q <= head_q;
            end else if (q.read_next && !q.empty) begin
                exec_q <= exec_q + 1'b1;
            end
        end
    end

endmodule

// File: mem_issue_ctrl.sv
/* Issue control
   Holds the next instruction until the cache and commit allow it, tracks the store in flight */
`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module mem_issue_ctrl
    import mem_unit_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 flush_i,
    queue_if.issue               q,
    input  logic                 dcache_ready_i,
    input  logic                 commit_store_i,
    input  logic                 store_done_i,
    input  logic                 replay_i,
    output logic                 dcache_req_valid_o,
    output mem_op_t              dcache_req_op_o,
    output logic [`MEM_XLEN-1:0] dcache_req_base_o,
    output logic [`MEM_XLEN-1:0] dcache_req_imm_o,
    output mem_instr_t           issued_instr_o,
    output logic                 mem_commit_stall_o,
    output logic [`MEM_GL_W-1:0] mem_gl_index_o
);

    typedef enum logic [1:0] {
        ReadHead,
        WaitReady,
        WaitCommit
    } state_t;

    state_t               state_q;
    state_t               next_state;
    mem_instr_t           held_q;
    mem_instr_t           cand_instr;
    logic                 cand_valid;
    logic                 cand_store;
    logic                 commit_ok;
    logic                 issue;
    logic                 store_in_flight_q;
    logic [`MEM_GL_W-1:0] store_gl_q;

    // Head of the queue when reading, held copy while waiting
    assign cand_instr = (state_q == ReadHead) ? q.head_instr : held_q;
    assign cand_valid = (state_q == ReadHead) ? ~q.empty : 1'b1;
    assign cand_store = is_store(cand_instr.op);

    // Loads go freely, a store needs commit and no other store out
    assign commit_ok = ~cand_store | (commit_store_i & ~store_in_flight_q);

    ////////////////////////////////////////////////////////////////////////////
    // Issue FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state_q;
        issue      = 1'b0;
        if (cand_valid) begin
            if (dcache_ready_i && commit_ok) begin
                issue      = ~flush_i & ~replay_i;
                next_state = ReadHead;
            end else if (!commit_ok) begin
                next_state = WaitCommit;
            end else begin
                next_state = WaitReady;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ReadHead;
        end else if (flush_i || replay_i) begin
            state_q <= ReadHead;
        end else begin
            state_q <= next_state;
        end
    end

    // Copy of the head taken each cycle the FSM reads the queue
    always_ff @(posedge clk_i) begin
        if (state_q == ReadHead) begin
            held_q <= q.head_instr;
        end
    end

    assign q.read_next = issue;   // Pointer moves only once the request is taken

    ////////////////////////////////////////////////////////////////////////////
    // Store in flight
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            store_in_flight_q <= 1'b0;
            store_gl_q        <= '0;
        end else if (flush_i || replay_i) begin
            store_in_flight_q <= 1'b0;   // Replayed store goes out again
        end else if (issue && cand_store) begin
            store_in_flight_q <= 1'b1;
            store_gl_q        <= cand_instr.gl_index;
        end else if (store_done_i) begin
            store_in_flight_q <= 1'b0;
        end
    end

    assign mem_commit_stall_o = ~flush_i &
                                ((cand_valid & cand_store & commit_store_i) |
                                 (store_in_flight_q & ~store_done_i));

    assign mem_gl_index_o = (cand_valid && cand_store && !store_in_flight_q) ?
                            cand_instr.gl_index : store_gl_q;

    // Request to the data cache
    assign dcache_req_valid_o = issue;
    assign dcache_req_op_o    = cand_instr.op;
    assign dcache_req_base_o  = cand_instr.base;
    assign dcache_req_imm_o   = cand_instr.imm;

    always_comb begin
        issued_instr_o       = cand_instr;
        issued_instr_o.valid = issue;
    end

endmodule

// File: mem_resp_stage.sv
/* Response stage
   Two pipeline stages, exception decode, nack replay and in-order writeback */
`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module mem_resp_stage
    import mem_unit_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  mem_instr_t             issued_instr_i,
    queue_if.resp                  q,
    input  logic                   dcache_resp_valid_i,
    input  logic                   dcache_nack_i,
    input  logic [`MEM_XLEN-1:0]   dcache_resp_data_i,
    input  logic [`MEM_XLEN-1:0]   dcache_resp_addr_i,
    input  logic                   dcache_xcpt_ma_i,
    input  logic                   dcache_xcpt_pf_i,
    output logic [`MEM_XLEN-1:0]   dcache_req_data_o,
    output logic                   store_done_o,
    output logic                   replay_o,
    output logic                   wb_valid_o,
    output logic [`MEM_PREG_W-1:0] wb_prd_o,
    output logic [`MEM_GL_W-1:0]   wb_gl_index_o,
    output logic [`MEM_XLEN-1:0]   wb_data_o,
    output exc_t                   wb_xcpt_o,
    output exc_t                   commit_xcpt_o
);

    localparam int SIGN_BIT = `MEM_VA_BITS - 1;

    mem_instr_t                    s1_q;
    mem_instr_t                    s2_q;
    logic                          s1_valid_q;
    logic                          s2_valid_q;
    logic                          s2_live;
    logic                          s2_store;
    logic                          resp_ok;
    logic                          replay;
    logic [`MEM_XLEN-1:SIGN_BIT]   addr_upper;
    logic                          non_canonical;
    exc_t                          exc;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline s1 and s2
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i || replay) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= issued_instr_i.valid;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_q <= issued_instr_i;
        s2_q <= s1_q;
    end

    assign dcache_req_data_o = s1_q.data;   // Store data one cycle after the request

    // Cache answers in s2 with either valid or nack
    assign s2_live  = s2_valid_q & ~flush_i;
    assign s2_store = is_store(s2_q.op);
    assign replay   = s2_live & dcache_nack_i;
    assign resp_ok  = s2_live & dcache_resp_valid_i & ~dcache_nack_i;

    ////////////////////////////////////////////////////////////////////////////
    // Exception decode
    ////////////////////////////////////////////////////////////////////////////

    // Bits above the sign bit must all copy it
    assign addr_upper    = dcache_resp_addr_i[`MEM_XLEN-1:SIGN_BIT];
    assign non_canonical = (|addr_upper) & ~(&addr_upper);

    always_comb begin
        exc = '0;
        if (dcache_xcpt_ma_i) begin
            exc.valid = 1'b1;
            exc.cause = s2_store ? ST_MISALIGNED : LD_MISALIGNED;
        end else if (dcache_xcpt_pf_i) begin
            exc.valid = 1'b1;
            exc.cause = s2_store ? ST_PAGE_FAULT : LD_PAGE_FAULT;
        end else if (non_canonical) begin
            exc.valid = 1'b1;
            exc.cause = s2_store ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
        end
        if (exc.valid) begin
            exc.tval = dcache_resp_addr_i;   // Faulting address
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Queue control and outputs
    ////////////////////////////////////////////////////////////////////////////

    assign q.retire = resp_ok;
    assign q.replay = replay;
    assign replay_o = replay;

    assign store_done_o = resp_ok & s2_store;

    // Loads to writeback, store faults to commit
    assign wb_valid_o    = resp_ok & ~s2_store;
    assign wb_prd_o      = s2_q.prd;
    assign wb_gl_index_o = s2_q.gl_index;
    assign wb_data_o     = dcache_resp_data_i;
    assign wb_xcpt_o     = wb_valid_o ? exc : '0;
    assign commit_xcpt_o = store_done_o ? exc : '0;

endmodule

// File: mem_unit.sv
/* Memory unit top level
   Load/store queue, issue control and response stage behind plain ports */
`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module mem_unit
    import mem_unit_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    // New instruction
    input  logic                   instr_valid_i,
    input  mem_op_t                instr_op_i,
    input  logic [`MEM_XLEN-1:0]   instr_base_i,
    input  logic [`MEM_XLEN-1:0]   instr_imm_i,
    input  logic [`MEM_XLEN-1:0]   instr_data_i,
    input  logic [`MEM_GL_W-1:0]   instr_gl_index_i,
    input  logic [`MEM_PREG_W-1:0] instr_prd_i,
    input  logic                   commit_store_i,
    // Data cache
    input  logic                   dcache_ready_i,
    input  logic                   dcache_resp_valid_i,
    input  logic                   dcache_nack_i,
    input  logic [`MEM_XLEN-1:0]   dcache_resp_data_i,
    input  logic [`MEM_XLEN-1:0]   dcache_resp_addr_i,
    input  logic                   dcache_xcpt_ma_i,
    input  logic                   dcache_xcpt_pf_i,
    output logic                   dcache_req_valid_o,
    output mem_op_t                dcache_req_op_o,
    output logic [`MEM_XLEN-1:0]   dcache_req_base_o,
    output logic [`MEM_XLEN-1:0]   dcache_req_imm_o,
    output logic [`MEM_XLEN-1:0]   dcache_req_data_o,
    output logic                   dcache_kill_o,
    // Writeback
    output logic                   wb_valid_o,
    output logic [`MEM_PREG_W-1:0] wb_prd_o,
    output logic [`MEM_GL_W-1:0]   wb_gl_index_o,
    output logic [`MEM_XLEN-1:0]   wb_data_o,
    output logic                   wb_xcpt_valid_o,
    output exc_cause_t             wb_xcpt_cause_o,
    output logic [`MEM_XLEN-1:0]   wb_xcpt_tval_o,
    // Commit
    output logic                   commit_xcpt_valid_o,
    output exc_cause_t             commit_xcpt_cause_o,
    output logic [`MEM_XLEN-1:0]   commit_xcpt_tval_o,
    output logic                   mem_commit_stall_o,
    output logic [`MEM_GL_W-1:0]   mem_gl_index_o,
    output logic                   lock_o,
    output logic                   empty_o
);

    mem_instr_t new_instr;
    mem_instr_t issued_instr;
    logic       lsq_full;
    logic       store_done;
    logic       replay;
    exc_t       wb_xcpt;
    exc_t       commit_xcpt;

    queue_if q_if ();

    assign new_instr = '{valid:    instr_valid_i,
                         op:       instr_op_i,
                         base:     instr_base_i,
                         imm:      instr_imm_i,
                         data:     instr_data_i,
                         gl_index: instr_gl_index_i,
                         prd:      instr_prd_i};

    load_store_queue i_lsq (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (flush_i),
        .instr_i (new_instr),
        .full_o  (lsq_full),
        .q       (q_if.lsq)
    );

    mem_issue_ctrl i_issue (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .flush_i            (flush_i),
        .q                  (q_if.issue),
        .dcache_ready_i     (dcache_ready_i),
        .commit_store_i     (commit_store_i),
        .store_done_i       (store_done),
        .replay_i           (replay),
        .dcache_req_valid_o (dcache_req_valid_o),
        .dcache_req_op_o    (dcache_req_op_o),
        .dcache_req_base_o  (dcache_req_base_o),
        .dcache_req_imm_o   (dcache_req_imm_o),
        .issued_instr_o     (issued_instr),
        .mem_commit_stall_o (mem_commit_stall_o),
        .mem_gl_index_o     (mem_gl_index_o)
    );

    mem_resp_stage i_resp (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .flush_i             (flush_i),
        .issued_instr_i      (issued_instr),
        .q                   (q_if.resp),
        .dcache_resp_valid_i (dcache_resp_valid_i),
        .dcache_nack_i       (dcache_nack_i),
        .dcache_resp_data_i  (dcache_resp_data_i),
        .dcache_resp_addr_i  (dcache_resp_addr_i),
        .dcache_xcpt_ma_i    (dcache_xcpt_ma_i),
        .dcache_xcpt_pf_i    (dcache_xcpt_pf_i),
        .dcache_req_data_o   (dcache_req_data_o),
        .store_done_o        (store_done),
        .replay_o            (replay),
        .wb_valid_o          (wb_valid_o),
        .wb_prd_o            (wb_prd_o),
        .wb_gl_index_o       (wb_gl_index_o),
        .wb_data_o           (wb_data_o),
        .wb_xcpt_o           (wb_xcpt),
        .commit_xcpt_o       (commit_xcpt)
    );

    assign wb_xcpt_valid_o     = wb_xcpt.valid;
    assign wb_xcpt_cause_o     = wb_xcpt.cause;
    assign wb_xcpt_tval_o      = wb_xcpt.tval;
    assign commit_xcpt_valid_o = commit_xcpt.valid;
    assign commit_xcpt_cause_o = commit_xcpt.cause;
    assign commit_xcpt_tval_o  = commit_xcpt.tval;

    assign dcache_kill_o = flush_i;
    assign lock_o        = lsq_full;     // Upstream must hold new instructions
    assign empty_o       = q_if.empty;

endmodule

// File: mem_unit_cfg.svh
/* Memory unit configuration
   Data width, queue depth and index widths */
`ifndef MEM_UNIT_CFG_SVH
`define MEM_UNIT_CFG_SVH

// Data and address width
`define MEM_XLEN        64

// Load/store queue entries, power of two
`define MEM_LSQ_DEPTH   8

`define MEM_GL_W        6   // Graduation list index
`define MEM_PREG_W      6   // Physical destination register

// Virtual address bits, the top one is the sign bit
`define MEM_VA_BITS     40

`endif

// File: mem_unit_pkg.sv
/* Memory unit types
   Operations, exception causes and the queued instruction word */
`include "mem_unit_cfg.svh"

package mem_unit_pkg;

    typedef enum logic [3:0] {
        LB, LH, LW, LD,
        LBU, LHU, LWU,
        SB, SH, SW, SD
    } mem_op_t;

    // RISC-V mcause codes for data accesses
    typedef enum logic [3:0] {
        LD_MISALIGNED   = 4'd4,
        LD_ACCESS_FAULT = 4'd5,
        ST_MISALIGNED   = 4'd6,
        ST_ACCESS_FAULT = 4'd7,
        LD_PAGE_FAULT   = 4'd13,
        ST_PAGE_FAULT   = 4'd15
    } exc_cause_t;

    typedef struct packed {
        logic                   valid;
        mem_op_t                op;
        logic [`MEM_XLEN-1:0]   base;
        logic [`MEM_XLEN-1:0]   imm;
        logic [`MEM_XLEN-1:0]   data;       // Store data
        logic [`MEM_GL_W-1:0]   gl_index;
        logic [`MEM_PREG_W-1:0] prd;
    } mem_instr_t;

    typedef struct packed {
        logic                 valid;
        exc_cause_t           cause;
        logic [`MEM_XLEN-1:0] tval;
    } exc_t;

    function automatic logic is_store(mem_op_t op);
        return op inside {SB, SH, SW, SD};
    endfunction

    // Access size in bytes
    function automatic logic [3:0] op_size_bytes(mem_op_t op);
        case (op)
            LB, LBU, SB: return 4'd1;
            LH, LHU, SH: return 4'd2;
            LW, LWU, SW: return 4'd4;
            default:     return 4'd8;
        endcase
    endfunction

endpackage

// File: queue_if.sv
/* Queue port
   Links the load/store queue with issue control and the response stage */
`timescale 1ns/1ps

interface queue_if
    import mem_unit_pkg::*;
();

    mem_instr_t head_instr;     // Entry at the execution pointer
    logic       empty;          // Nothing left to issue
    logic       read_next;      // Advance execution pointer
    logic       retire;         // Free the head entry
    logic       replay;         // Rewind execution pointer to head

    modport lsq (
        output head_instr,
        output empty,
        input  read_next,
        input  retire,
        input  replay
    );

    modport issue (
        input  head_instr,
        input  empty,
        output read_next
    );

    modport resp (
        output retire,
        output replay
    );

endinterface

// File: run_sim.sh
#!/bin/sh
# Build the memory unit testbench with Verilator and run it

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_mem_unit -f sources.f -o tb_mem_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0

// File: sources.f
+incdir+.
mem_unit_pkg.sv
queue_if.sv
load_store_queue.sv
mem_issue_ctrl.sv
mem_resp_stage.sv
mem_unit.sv
tb_mem_unit.sv

// File: tb_mem_unit.sv
/* Memory unit testbench
   Random loads and stores against a cache model and an in-order reference model */
`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module tb_mem_unit
    import mem_unit_pkg::*;
();

    localparam longint WD_NS = 64'd460 * 40 * 40 + 16 * 40 + 4000;  // 460 instructions

    typedef struct packed {
        logic                 valid;
        logic                 nack;
        logic                 pf;
        logic [`MEM_XLEN-1:0] sdata;    // Store data seen one cycle after issue
        mem_instr_t           ins;
    } slot_t;

    logic clk_i, rstn_i, flush_i, instr_valid_i, commit_store_i, dcache_ready_i;
    mem_op_t instr_op_i, dcache_req_op_o;
    logic [`MEM_XLEN-1:0] instr_base_i, instr_imm_i, instr_data_i;
    logic [`MEM_GL_W-1:0] instr_gl_index_i, wb_gl_index_o, mem_gl_index_o;
    logic [`MEM_PREG_W-1:0] instr_prd_i, wb_prd_o;
    logic dcache_resp_valid_i, dcache_nack_i, dcache_xcpt_ma_i, dcache_xcpt_pf_i;
    logic [`MEM_XLEN-1:0] dcache_resp_data_i, dcache_resp_addr_i;
    logic dcache_req_valid_o, dcache_kill_o, wb_valid_o, wb_xcpt_valid_o;
    logic [`MEM_XLEN-1:0] dcache_req_base_o, dcache_req_imm_o, dcache_req_data_o;
    logic [`MEM_XLEN-1:0] wb_data_o, wb_xcpt_tval_o, commit_xcpt_tval_o;
    exc_cause_t wb_xcpt_cause_o, commit_xcpt_cause_o;
    logic commit_xcpt_valid_o, mem_commit_stall_o, lock_o, empty_o;

    integer seed;
    int errors, tests, tests_failed, issue_ptr, sent;
    int nack_pct, ready_pct, commit_pct, xcpt_on;
    logic check_empty;
    slot_t slot_new, slot_a, slot_b;
    mem_instr_t refq [$];
    logic [`MEM_XLEN-1:0] cache_mem [logic [`MEM_XLEN-1:0]];
    logic [`MEM_XLEN-1:0] ref_mem [logic [`MEM_XLEN-1:0]];

    mem_unit i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Watchdog sized from the total number of instructions
    initial begin
        #(WD_NS);
        $display("Timeout: the memory unit stopped making progress");
        $display("Test failed");
        $finish;
    end

    function automatic logic chance(int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    // Unwritten words return a pattern built from the whole address
    function automatic logic [`MEM_XLEN-1:0] fill_word(logic [`MEM_XLEN-1:0] addr);
        return {addr[31:0], ~addr[63:32]} ^ 64'h3c5a_96e1_0f87_d24b;
    endfunction

    function automatic exc_t expect_xcpt(mem_op_t op, logic [`MEM_XLEN-1:0] addr, logic pf);
        exc_t e;
        logic st;
        st = is_store(op);
        e  = '0;
        if (|(addr & (64'(op_size_bytes(op)) - 64'd1))) begin
            e.valid = 1'b1;
            e.cause = st ? ST_MISALIGNED : LD_MISALIGNED;
        end else if (pf) begin
            e.valid = 1'b1;
            e.cause = st ? ST_PAGE_FAULT : LD_PAGE_FAULT;
        end else if (addr[63:39] != '0 && addr[63:39] != '1) begin
            e.valid = 1'b1;
            e.cause = st ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
        end
        if (e.valid) e.tval = addr;
        return e;
    endfunction

    task automatic fail_value(string name, logic [71:0] exp, logic [71:0] got);
        errors++;
        $display("FAIL %s expected %h got %h", name, exp, got);
    endtask

    task automatic fail_msg(string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic check_wb(logic [`MEM_XLEN-1:0] data, logic [`MEM_PREG_W-1:0] prd,
                            logic [`MEM_GL_W-1:0] gl, exc_t x);
        exc_t got;
        got = '{valid: wb_xcpt_valid_o, cause: wb_xcpt_cause_o, tval: wb_xcpt_tval_o};
        if (!x.valid && wb_data_o !== data) fail_value("wb_data_o", 72'(data), 72'(wb_data_o));
        if (wb_prd_o !== prd) fail_value("wb_prd_o", 72'(prd), 72'(wb_prd_o));
        if (wb_gl_index_o !== gl) fail_value("wb_gl_index_o", 72'(gl), 72'(wb_gl_index_o));
        if (got !== x) fail_value("wb_xcpt", 72'(x), 72'(got));
    endtask

    task automatic check_commit_xcpt(exc_t x);
        exc_t got;
        got = '{valid: commit_xcpt_valid_o, cause: commit_xcpt_cause_o,
                tval: commit_xcpt_tval_o};
        if (got !== x) fail_value("commit_xcpt", 72'(x), 72'(got));
    endtask

    task automatic check_store_stall(logic [`MEM_GL_W-1:0] gl);
        if (!mem_commit_stall_o) fail_msg("commit not stalled while a store is out");
        if (mem_gl_index_o !== gl) fail_value("mem_gl_index_o", 72'(gl), 72'(mem_gl_index_o));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One clock cycle of stimulus, cache model and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic step(logic flush_now, logic may_write);
        mem_instr_t ins;
        mem_instr_t front;
        exc_t ex;
        logic [`MEM_XLEN-1:0] addr;
        @(negedge clk_i);
        slot_b   = slot_a;
        slot_a   = slot_new;
        slot_new = '0;
        if (lock_o !== (refq.size() == `MEM_LSQ_DEPTH)) fail_msg("lock_o disagrees with occupancy");
        if (check_empty && !empty_o) fail_msg("queue not empty after flush");
        check_empty = flush_now;

        flush_i        = flush_now;
        dcache_ready_i = chance(ready_pct);
        commit_store_i = chance(commit_pct);
        instr_valid_i  = 1'b0;
        if (may_write && !flush_now && refq.size() < `MEM_LSQ_DEPTH && chance(70)) begin
            ins          = '0;
            ins.valid    = 1'b1;
            ins.op       = mem_op_t'(4'($unsigned($random(seed)) % 11));
            ins.base     = 64'($unsigned($random(seed)) % 16) << 3;
            ins.imm      = xcpt_on != 0 ? 64'($unsigned($random(seed)) % 8) : '0;
            if (xcpt_on != 0 && chance(15)) ins.base[63] = 1'b1;  // Not canonical
            ins.data     = {$random(seed), $random(seed)};
            ins.gl_index = 6'(sent);
            ins.prd      = 6'($random(seed));
            instr_op_i       = ins.op;
            instr_base_i     = ins.base;
            instr_imm_i      = ins.imm;
            instr_data_i     = ins.data;
            instr_gl_index_i = ins.gl_index;
            instr_prd_i      = ins.prd;
            instr_valid_i    = 1'b1;
            refq.push_back(ins);
            sent++;
        end

        // Cache answers the request taken two cycles ago
        {dcache_resp_valid_i, dcache_nack_i, dcache_xcpt_ma_i, dcache_xcpt_pf_i} = '0;
        dcache_resp_data_i = '0;
        dcache_resp_addr_i = '0;
        addr = slot_b.ins.base + slot_b.ins.imm;
        if (slot_b.valid && !flush_now) begin
            dcache_resp_addr_i = addr;
            if (slot_b.nack) begin
                dcache_nack_i = 1'b1;
            end else begin
                dcache_resp_valid_i = 1'b1;
                dcache_xcpt_ma_i    = |(addr & (64'(op_size_bytes(slot_b.ins.op)) - 64'd1));
                dcache_xcpt_pf_i    = slot_b.pf;
                if (!dcache_xcpt_ma_i && !dcache_xcpt_pf_i) begin
                    if (is_store(slot_b.ins.op)) begin
                        cache_mem[addr >> 3] = slot_b.sdata;
                    end else begin
                        dcache_resp_data_i = cache_mem.exists(addr >> 3) ?
                                             cache_mem[addr >> 3] : fill_word(addr >> 3);
                    end
                end
            end
        end

        #1;
        if (dcache_req_valid_o && !dcache_ready_i) fail_msg("request raised while not ready");
        if (dcache_kill_o !== flush_now) begin
            fail_value("dcache_kill_o", 72'(flush_now), 72'(dcache_kill_o));
        end
        if (dcache_resp_valid_i) begin
            front = refq.pop_front();
            issue_ptr--;
            ex = expect_xcpt(front.op, front.base + front.imm, slot_b.pf);
            if (is_store(front.op)) begin
                if (wb_valid_o) fail_msg("store produced a writeback");
                check_commit_xcpt(ex);
                if (slot_b.sdata !== front.data) begin
                    fail_value("dcache_req_data_o", 72'(front.data), 72'(slot_b.sdata));
                end
                if (!ex.valid) ref_mem[addr >> 3] = front.data;
            end else begin
                if (!wb_valid_o) begin
                    fail_msg("completed load did not write back");
                end else begin
                    check_wb(ref_mem.exists(addr >> 3) ? ref_mem[addr >> 3] : fill_word(addr >> 3),
                             front.prd, front.gl_index, ex);
                end
                check_commit_xcpt('0);
            end
        end else begin
            if (wb_valid_o) fail_msg("writeback without a completed load");
            check_commit_xcpt('0);
        end

        if (slot_a.valid && !flush_now) begin
            slot_a.sdata = dcache_req_data_o;
            if (is_store(slot_a.ins.op)) check_store_stall(slot_a.ins.gl_index);
        end

        if (dcache_req_valid_o && dcache_ready_i) begin
            if (issue_ptr >= refq.size()) begin
                fail_msg("request issued with no instruction pending");
            end else begin
                ins = refq[issue_ptr];
                if (dcache_req_op_o !== ins.op) begin
                    fail_value("dcache_req_op_o", 72'(ins.op), 72'(dcache_req_op_o));
                end
                if (dcache_req_base_o !== ins.base) begin
                    fail_value("dcache_req_base_o", 72'(ins.base), 72'(dcache_req_base_o));
                end
                if (dcache_req_imm_o !== ins.imm) begin
                    fail_value("dcache_req_imm_o", 72'(ins.imm), 72'(dcache_req_imm_o));
                end
                if (is_store(ins.op)) begin
                    if (!commit_store_i) fail_msg("store issued without commit");
                    if ((slot_a.valid && is_store(slot_a.ins.op)) ||
                        (slot_b.valid && is_store(slot_b.ins.op))) begin
                        fail_msg("second store issued while one is in flight");
                    end
                    check_store_stall(ins.gl_index);
                end
                slot_new = '{valid: 1'b1, nack: chance(nack_pct),
                             pf: xcpt_on != 0 && chance(20), sdata: '0, ins: ins};
                issue_ptr++;
            end
        end

        if (dcache_nack_i) begin
            issue_ptr = 0;      // Everything after the head is issued again
            slot_a    = '0;
        end
        if (flush_now) begin
            refq.delete();
            issue_ptr = 0;
            slot_a    = '0;
        end
    endtask

    task automatic run_test(string name, int n, int nk, int rd, int cm, int xc, int flush_at);
        int cyc;
        int errs_before;
        nack_pct    = nk;
        ready_pct   = rd;
        commit_pct  = cm;
        xcpt_on     = xc;
        errs_before = errors;
        sent        = 0;
        cyc         = 0;
        while (sent < n || refq.size() != 0) begin
            step(cyc == flush_at, sent < n);
            cyc++;
        end
        tests++;
        if (errors != errs_before) tests_failed++;
        $display("%-26s %0d instructions, %0d errors", name, n, errors - errs_before);
    endtask

    initial begin
        seed = 32'h60a7_97c8;
        {errors, tests, tests_failed, issue_ptr, sent} = '0;
        {slot_new, slot_a, slot_b} = '0;
        check_empty = 1'b0;
        rstn_i = 1'b0;
        {flush_i, instr_valid_i, commit_store_i, dcache_ready_i} = '0;
        instr_op_i = LB;
        {instr_base_i, instr_imm_i, instr_data_i, instr_gl_index_i, instr_prd_i} = '0;
        {dcache_resp_valid_i, dcache_nack_i, dcache_xcpt_ma_i, dcache_xcpt_pf_i} = '0;
        {dcache_resp_data_i, dcache_resp_addr_i} = '0;
        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;

        run_test("in-order loads and stores", 60, 0, 100, 100, 0, -1);
        run_test("commit gating", 60, 0, 100, 30, 0, -1);
        run_test("nack replay", 80, 25, 100, 70, 0, -1);
        run_test("ready back-pressure", 80, 10, 40, 70, 0, -1);
        run_test("exceptions", 120, 10, 80, 70, 1, -1);
        run_test("flush", 60, 10, 80, 70, 0, 30);

        $display("%0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
